// File: build.f
hw/csr_cfg_pkg.sv
hw/sync_fifo.sv
hw/response_filter.sv
hw/config_assembler.sv
hw/csr_index_configure_memory.sv
dv/tb_csr_index_configure_memory.sv

// File: run.sh
#!/bin/sh
# Builds the CSR index loader testbench with Verilator, runs it, and reports pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_csr_index_configure_memory \
    --Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// File: dv/tb_csr_index_configure_memory.sv
// Testbench for the CSR index loader, drives response windows and compares records with a model
`timescale 1ns/100ps

module tb_csr_index_configure_memory
    import csr_cfg_pkg::*;
;

    localparam int engine_slot = 1;
    localparam int window_base = engine_slot * engine_seq_width;

    // Words sent by tests 1 to 5: 16 + 48 + 22 + 80 + 32
    localparam int total_words    = 198;
    localparam int timeout_cycles = total_words * 20 + 2000;

    typedef data_word_t [engine_seq_width-1:0] window_t;

    logic             ap_clk;
    logic             areset_csr_index_generator;
    response_packet_t response_in;
    logic             config_pop;
    config_packet_t   config_out;

    logic [15:0]       lfsr_state;
    string             test_name;
    csr_index_config_t exp_q[$];
    string             name_q[$];
    int                out_count;

    csr_index_configure_memory #(
        .engine_slot(engine_slot)
    ) u_dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .config_pop                (config_pop),
        .config_out                (config_out)
    );

    always #50 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Failure handling and checks
    // ----------------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            $display("ERROR [%s] expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // Random data and reference model
    // ----------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output data_word_t value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_window(output window_t w);
        for (int i = 0; i < engine_seq_width; i++) begin
            random_word(w[i]);
        end
    endtask

    // Expected record from the word layout of one window
    function automatic csr_index_config_t expected_config(input window_t w);
        csr_index_config_t c;
        c               = '0;
        c.increment     = w[word_flags][flag_increment];
        c.decrement     = w[word_flags][flag_decrement];
        c.mode_sequence = w[word_flags][flag_mode_sequence];
        c.mode_buffer   = w[word_flags][flag_mode_buffer];
        c.mode_break    = w[word_flags][flag_mode_break];
        c.index_start   = w[word_index_start];
        c.index_end     = w[word_index_end];
        c.stride        = w[word_stride];
        c.granularity   = w[word_granularity][3:0];
        c.direction     = w[word_granularity][direction_bit];
        c.cmd           = memory_cmd_t'(w[word_cmd][1:0]);
        c.array_pointer = {w[word_ptr_hi], w[word_ptr_lo]};
        c.array_size    = w[word_array_size];
        return c;
    endfunction

    task automatic expect_record(input window_t w);
        exp_q.push_back(expected_config(w));
        name_q.push_back(test_name);
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic send_word(input buffer_kind_t kind, input int offset, input data_word_t data);
        @(negedge ap_clk);
        response_in.valid  = 1'b1;
        response_in.kind   = kind;
        response_in.offset = word_offset_t'(offset);
        response_in.data   = data;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge ap_clk);
            response_in.valid = 1'b0;
        end
    endtask

    task automatic send_window(input window_t w, input buffer_kind_t kind);
        for (int i = 0; i < engine_seq_width; i++) begin
            send_word(kind, window_base + i, w[i]);
        end
    endtask

    // Wait for every queued record, the watchdog covers a hang
    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge ap_clk);
        end
        idle_cycles(5);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge ap_clk) begin : compare_records
        csr_index_config_t expected;
        string             name;
        if (!areset_csr_index_generator && config_out.valid) begin
            if (exp_q.size() == 0) begin
                $display("A record came out of the DUT while none was expected");
                abort_run();
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                check_value(name, 256'(expected), 256'(config_out.payload));
                out_count = out_count + 1;
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge ap_clk);
        $display("Timeout after %0d cycles with %0d records still missing",
                 timeout_cycles, exp_q.size());
        abort_run();
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : run_tests
        window_t w;
        window_t w2;
        data_word_t junk;
        int count_before;

        ap_clk                     = 1'b0;
        areset_csr_index_generator = 1'b1;
        response_in                = '0;
        config_pop                 = 1'b0;
        lfsr_state                 = 16'd66;
        out_count                  = 0;
        test_name                  = "reset";
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;

        // Test 1: quiet after reset, then one window
        test_name  = "single_window";
        config_pop = 1'b1;
        repeat (8) begin
            @(negedge ap_clk);
            check_value("reset_idle", 256'(0), 256'(config_out.valid));
        end
        random_window(w);
        expect_record(w);
        send_window(w, buf_engine_setup);
        idle_cycles(1);
        wait_drained();

        // Test 2: foreign kinds and offsets mixed into a window
        test_name = "filtering";
        random_window(w);
        expect_record(w);
        for (int i = 0; i < engine_seq_width; i++) begin
            random_word(junk);
            send_word((i % 2 == 1) ? buf_data : buf_other, window_base + i, junk);
            random_word(junk);
            send_word(buf_engine_setup, (i % 2 == 1) ? i : 32 + i, junk);
            send_word(buf_engine_setup, window_base + i, w[i]);
        end
        idle_cycles(1);
        wait_drained();

        // Test 3: stray words before any base word
        test_name = "start_alignment";
        for (int i = 20; i <= 25; i++) begin
            random_word(junk);
            send_word(buf_engine_setup, i, junk);
        end
        idle_cycles(10);
        random_window(w);
        expect_record(w);
        send_window(w, buf_engine_setup);
        idle_cycles(1);
        wait_drained();

        // Test 4: records pile up while pop is low
        test_name    = "back_pressure";
        config_pop   = 1'b0;
        count_before = out_count;
        for (int n = 0; n < 5; n++) begin
            random_window(w);
            expect_record(w);
            send_window(w, (n % 2 == 1) ? buf_cu_setup : buf_engine_setup);
        end
        idle_cycles(60);
        check_value("pop_held_low", 256'(count_before), 256'(out_count));
        config_pop = 1'b1;
        wait_drained();

        // Test 5: words 6 and 10 to 15 do not reach the record
        test_name = "unused_words";
        random_window(w);
        w2 = w;
        random_word(w2[6]);
        for (int i = 10; i < engine_seq_width; i++) begin
            random_word(w2[i]);
        end
        expect_record(w);
        expect_record(w2);
        send_window(w, buf_engine_setup);
        send_window(w2, buf_cu_setup);
        idle_cycles(1);
        wait_drained();

        idle_cycles(20);
        if (exp_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("%0d expected records never came out of the DUT", exp_q.size());
            abort_run();
        end
    end

endmodule : tb_csr_index_configure_memory

// File: hw/csr_index_configure_memory.sv
// Top of the CSR index configuration loader, from memory responses to queued records
`timescale 1ns/100ps

module csr_index_configure_memory
    import csr_cfg_pkg::*;
#(
    parameter int engine_slot = 0
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  response_packet_t response_in,
    input  logic             config_pop,
    output config_packet_t   config_out
);

    // ----------------------------------------
    // Input side
    // ----------------------------------------
    logic              fifo_wr_en;
    response_payload_t fifo_din;
    response_payload_t resp_dout;
    logic              resp_valid;
    logic              resp_empty;
    logic              resp_rd_en;
    response_packet_t  response_word;

    // Output side
    config_packet_t    record_out;
    csr_index_config_t cfg_dout;
    logic              cfg_valid;
    logic              cfg_empty;
    logic              cfg_prog_full;
    logic              cfg_rd_en;

    response_filter #(
        .engine_slot(engine_slot)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .fifo_wr_en                (fifo_wr_en),
        .fifo_din                  (fifo_din)
    );

    sync_fifo #(
        .width($bits(response_payload_t))
    ) u_resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .din                       (fifo_din),
        .wr_en                     (fifo_wr_en),
        .rd_en                     (resp_rd_en),
        .dout                      (resp_dout),
        .valid                     (resp_valid),
        .empty                     (resp_empty),
        .full                      (),
        .prog_full                 ()
    );

    assign response_word.valid  = resp_valid;
    assign response_word.kind   = resp_dout.kind;
    assign response_word.offset = resp_dout.offset;
    assign response_word.data   = resp_dout.data;

    // ----------------------------------------
    // Decode and output queue
    // ----------------------------------------
    config_assembler #(
        .engine_slot(engine_slot)
    ) u_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_word             (response_word),
        .fifo_empty                (resp_empty),
        .out_prog_full             (cfg_prog_full),
        .resp_rd_en                (resp_rd_en),
        .record_out                (record_out)
    );

    // One record per cycle while the consumer holds pop high
    assign cfg_rd_en = config_pop & ~cfg_empty;

    sync_fifo #(
        .width($bits(csr_index_config_t))
    ) u_cfg_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .din                       (record_out.payload),
        .wr_en                     (record_out.valid),
        .rd_en                     (cfg_rd_en),
        .dout                      (cfg_dout),
        .valid                     (cfg_valid),
        .empty                     (cfg_empty),
        .full                      (),
        .prog_full                 (cfg_prog_full)
    );

    // Output register
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            config_out.valid <= 1'b0;
        end else begin
            config_out.valid <= cfg_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        config_out.payload <= cfg_dout;
    end

endmodule : csr_index_configure_memory

// File: hw/config_assembler.sv
// Walks one window of setup words and decodes them into a CSR index configuration record
`timescale 1ns/100ps

module config_assembler
    import csr_cfg_pkg::*;
#(
    parameter int engine_slot = 0
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  response_packet_t response_word,
    input  logic             fifo_empty,
    input  logic             out_prog_full,
    output logic             resp_rd_en,
    output config_packet_t   record_out
);

    // Offset of word 0 of this engine's window
    localparam word_offset_t slot_base = word_offset_t'(engine_slot * engine_seq_width);

    logic [engine_seq_width-1:0] position;
    logic [engine_seq_width-1:0] pos_cur;
    logic [engine_seq_width-1:0] pos_next;
    logic                        window_done;
    logic                        is_base;
    csr_index_config_t           cfg;

    // ----------------------------------------
    // Window position
    // ----------------------------------------
    // Last word taken, the record leaves this cycle
    assign window_done = position[engine_seq_width-1];

    // A finished window counts as idle, so a base word can follow right away
    assign pos_cur = window_done ? '0 : position;
    assign is_base = (response_word.offset == slot_base) & ~(|pos_cur);

    always_comb begin
        pos_next = pos_cur;
        if (response_word.valid) begin
            if (is_base) begin
                pos_next = engine_seq_width'(1);
            end else begin
                // Stray words with no open window shift a zero and vanish
                pos_next = pos_cur << 1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            position <= '0;
        end else begin
            position <= pos_next;
        end
    end

    // No reads while the record goes out or the output side is backing up
    assign resp_rd_en = ~fifo_empty & ~out_prog_full & ~window_done;

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (response_word.valid) begin
            case (1'b1)
                pos_next[word_flags]: begin
                    cfg.increment     <= response_word.data[flag_increment];
                    cfg.decrement     <= response_word.data[flag_decrement];
                    cfg.mode_sequence <= response_word.data[flag_mode_sequence];
                    cfg.mode_buffer   <= response_word.data[flag_mode_buffer];
                    cfg.mode_break    <= response_word.data[flag_mode_break];
                end
                pos_next[word_index_start]: begin
                    cfg.index_start <= response_word.data;
                end
                pos_next[word_index_end]: begin
                    cfg.index_end <= response_word.data;
                end
                pos_next[word_stride]: begin
                    cfg.stride <= response_word.data;
                end
                pos_next[word_granularity]: begin
                    cfg.granularity <= response_word.data[$bits(granularity_t)-1:0];
                    cfg.direction   <= response_word.data[direction_bit];
                end
                pos_next[word_cmd]: begin
                    cfg.cmd <= memory_cmd_t'(response_word.data[$bits(memory_cmd_t)-1:0]);
                end
                pos_next[word_ptr_lo]: begin
                    cfg.array_pointer[31:0] <= response_word.data;
                end
                pos_next[word_ptr_hi]: begin
                    cfg.array_pointer[63:32] <= response_word.data;
                end
                pos_next[word_array_size]: begin
                    cfg.array_size <= response_word.data;
                end
                // Words 6 and 10 to 15 carry nothing for this engine
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Record output
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            record_out.valid <= 1'b0;
        end else begin
            record_out.valid <= window_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        record_out.payload <= cfg;
    end

    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        $onehot0(position))
        else $error("config_assembler: window position not one-hot");

endmodule : config_assembler

// File: hw/response_filter.sv
// Input stage of the loader, keeps only setup words that fall into this engine's window
`timescale 1ns/100ps

module response_filter
    import csr_cfg_pkg::*;
#(
    parameter int engine_slot = 0
) (
    input  logic              ap_clk,
    input  logic              areset_csr_index_generator,
    input  response_packet_t  response_in,
    output logic              fifo_wr_en,
    output response_payload_t fifo_din
);

    // First and one-past-last offset of the window
    localparam int unsigned window_lo = engine_slot * engine_seq_width;
    localparam int unsigned window_hi = window_lo + engine_seq_width;

    logic              resp_valid;
    response_payload_t resp_payload;
    logic              is_setup;
    logic              in_window;

    // ----------------------------------------
    // Input register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_payload.kind   <= response_in.kind;
        resp_payload.offset <= response_in.offset;
        resp_payload.data   <= response_in.data;
    end

    // ----------------------------------------
    // Window match
    // ----------------------------------------
    assign is_setup = (resp_payload.kind == buf_cu_setup) |
                      (resp_payload.kind == buf_engine_setup);

    assign in_window = (32'(resp_payload.offset) >= window_lo) &
                       (32'(resp_payload.offset) <  window_hi);

    assign fifo_wr_en = resp_valid & is_setup & in_window;
    assign fifo_din   = resp_payload;

endmodule : response_filter

// File: hw/sync_fifo.sv
// Synchronous FIFO with registered read data and a programmable full level, one per queue
`timescale 1ns/100ps

module sync_fifo
    import csr_cfg_pkg::*;
#(
    parameter int width = 32
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic [width-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int ptr_w = $clog2(fifo_depth);

    logic [width-1:0] mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_wr;
    logic             do_rd;

    // Writes to a full queue and reads from an empty one are dropped
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == (ptr_w + 1)'(fifo_depth));
    assign prog_full = (count >= (ptr_w + 1)'(fifo_prog_thresh));

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= do_rd;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        wr_en |-> !full)
        else $error("sync_fifo: write while full, word dropped");

    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        rd_en |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule : sync_fifo

// File: hw/csr_cfg_pkg.sv
// Shared types and constants of the CSR index configuration loader, imported by every block
package csr_cfg_pkg;

    // ----------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------
    typedef logic [31:0] data_word_t;
    typedef logic [15:0] word_offset_t;
    typedef logic [31:0] index_t;
    typedef logic [63:0] array_ptr_t;
    typedef logic [3:0]  granularity_t;

    // Tag that says which buffer a response word belongs to
    typedef enum logic [1:0] {
        buf_other        = 2'd0,
        buf_cu_setup     = 2'd1,
        buf_engine_setup = 2'd2,
        buf_data         = 2'd3
    } buffer_kind_t;

    typedef enum logic [1:0] {
        cmd_invalid = 2'd0,
        cmd_read    = 2'd1,
        cmd_write   = 2'd2,
        cmd_stream  = 2'd3
    } memory_cmd_t;

    // ----------------------------------------
    // Window layout
    // ----------------------------------------
    localparam int engine_seq_width = 16;

    // Word positions inside one window
    localparam int word_flags       = 0;
    localparam int word_index_start = 1;
    localparam int word_index_end   = 2;
    localparam int word_stride      = 3;
    localparam int word_granularity = 4;
    localparam int word_cmd         = 5;
    localparam int word_ptr_lo      = 7;
    localparam int word_ptr_hi      = 8;
    localparam int word_array_size  = 9;

    // Bits of the flags word
    localparam int flag_increment     = 0;
    localparam int flag_decrement     = 1;
    localparam int flag_mode_sequence = 2;
    localparam int flag_mode_buffer   = 3;
    localparam int flag_mode_break    = 4;

    // Direction sits in the top bit of the granularity word
    localparam int direction_bit = 31;

    // Queue sizing, shared by both FIFOs
    localparam int fifo_depth       = 16;
    localparam int fifo_prog_thresh = 8;

    // ----------------------------------------
    // Packets
    // ----------------------------------------
    typedef struct packed {
        logic         valid;
        buffer_kind_t kind;
        word_offset_t offset;
        data_word_t   data;
    } response_packet_t;

    typedef struct packed {
        buffer_kind_t kind;
        word_offset_t offset;
        data_word_t   data;
    } response_payload_t;

    typedef struct packed {
        logic         increment;
        logic         decrement;
        logic         mode_sequence;
        logic         mode_buffer;
        logic         mode_break;
        index_t       index_start;
        index_t       index_end;
        index_t       stride;
        index_t       array_size;
        granularity_t granularity;
        logic         direction;
        memory_cmd_t  cmd;
        array_ptr_t   array_pointer;
    } csr_index_config_t;

    typedef struct packed {
        logic              valid;
        csr_index_config_t payload;
    } config_packet_t;

endpackage : csr_cfg_pkg
